// ==== rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [11:0] csr_addr_t;

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_ADD  = 3'b000; // add sub addi
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101; // srl sra and the imm forms
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_SB    = 3'b000;
	localparam logic [2:0] F3_SH    = 3'b001;
	localparam logic [2:0] F3_SW    = 3'b010;
	localparam logic [2:0] F3_CSRRW = 3'b001;
	localparam logic [2:0] F3_CSRRS = 3'b010;

	localparam csr_addr_t CSR_MSCRATCH = 12'h340;
	localparam csr_addr_t CSR_MEPC     = 12'h341;

endpackage

`default_nettype wire

// ==== rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

	// instruction format as picked from the opcode in decode
	typedef enum logic [2:0] {
		FMT_R = 3'd0,
		FMT_I = 3'd1,
		FMT_S = 3'd2,
		FMT_B = 3'd3,
		FMT_U = 3'd4,
		FMT_J = 3'd5
	} fmt_e;

	// alu operator that also keys the result selector
	typedef enum logic [3:0] {
		OP_ADD   = 4'd0,
		OP_SUB   = 4'd1,
		OP_AND   = 4'd2,
		OP_XOR   = 4'd3,
		OP_OR    = 4'd4,
		OP_SRL   = 4'd5,
		OP_SRA   = 4'd6,
		OP_SLL   = 4'd7,
		OP_LESS  = 4'd8, // signed compare
		OP_ULESS = 4'd9  // unsigned compare
	} alu_op_e;

endpackage

`default_nettype wire

// ==== mux_key.sv ====
`timescale 1ns/1ps
`default_nettype none

module mux_key #(
	parameter int NR_KEY   = 2,
	parameter int KEY_LEN  = 1,
	parameter int DATA_LEN = 1
) (
	input  wire logic [KEY_LEN-1:0]                   key,
	input  wire logic [DATA_LEN-1:0]                  default_out,
	input  wire logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] lut,
	output logic      [DATA_LEN-1:0]                  out
);

	localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

	// each entry is {key, data} with the first entry of the concatenation on top
	always_comb begin
		out = default_out;
		for (int i = 0; i < NR_KEY; i++) begin
			if (lut[i*PAIR_LEN+DATA_LEN +: KEY_LEN] == key) begin
				out = lut[i*PAIR_LEN +: DATA_LEN];
			end
		end
	end

endmodule

`default_nettype wire

// ==== rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_isa_pkg::*; #(
	parameter int NR_REGS = 32
) (
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire reg_idx_t rs1,
	input  wire reg_idx_t rs2,
	output word_t         rdata1,
	output word_t         rdata2,
	input  wire logic     wen,
	input  wire reg_idx_t waddr,
	input  wire word_t    wdata
);

	word_t regs [NR_REGS];

	// x0 and anything past the implemented file read as zero
	assign rdata1 = (rs1 != '0 && rs1 < NR_REGS) ? regs[rs1] : '0;
	assign rdata2 = (rs2 != '0 && rs2 < NR_REGS) ? regs[rs2] : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NR_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != '0 && waddr < NR_REGS) begin
			regs[waddr] <= wdata;
		end
	end

endmodule

`default_nettype wire

// ==== rv_idu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_idu import rv_isa_pkg::*, rv_exec_pkg::*; (
	input  wire inst_t inst,
	output logic [6:0] opcode,
	output fmt_e       fmt,
	output logic [2:0] funct3,
	output logic [6:0] funct7,
	output reg_idx_t   rs1,
	output reg_idx_t   rs2,
	output reg_idx_t   rd,
	output word_t      imm,
	output logic       rd_wen,
	output logic       st_en,
	output logic       csr_en,
	output csr_addr_t  csr_addr
);

	logic known; // opcode is one we execute

	assign opcode   = inst[6:0];
	assign funct3   = inst[14:12];
	assign funct7   = inst[31:25];
	assign rs1      = inst[19:15];
	assign rs2      = inst[24:20];
	assign rd       = inst[11:7];
	assign csr_addr = inst[31:20];

	always_comb begin
		known = 1'b1;
		case (opcode)
			OPC_LUI, OPC_AUIPC: fmt = FMT_U;
			OPC_JAL:            fmt = FMT_J;
			OPC_JALR:           fmt = FMT_I;
			OPC_BRANCH:         fmt = FMT_B;
			OPC_STORE:          fmt = FMT_S;
			OPC_OP_IMM:         fmt = FMT_I;
			OPC_OP:             fmt = FMT_R;
			OPC_SYSTEM:         fmt = FMT_I; // csr number sits in the imm field
			default: begin
				fmt   = FMT_R;
				known = 1'b0;
			end
		endcase
	end

	// sign-extended immediate per format
	always_comb begin
		case (fmt)
			FMT_I:   imm = {{20{inst[31]}}, inst[31:20]};
			FMT_S:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			FMT_B:   imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			FMT_U:   imm = {inst[31:12], 12'b0};
			FMT_J:   imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			default: imm = '0; // R has none
		endcase
	end

	// only csrrw and csrrs are handled
	assign csr_en = (opcode == OPC_SYSTEM) && (funct3 == F3_CSRRW || funct3 == F3_CSRRS);
	assign st_en  = (opcode == OPC_STORE);

	always_comb begin
		rd_wen = known && fmt != FMT_S && fmt != FMT_B;
		if (opcode == OPC_SYSTEM) begin
			rd_wen = csr_en; // ecall and friends write nothing
		end
	end

endmodule

`default_nettype wire

// ==== rv_exu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exu import rv_isa_pkg::*, rv_exec_pkg::*; (
	input  wire logic [6:0] opcode,
	input  wire fmt_e       fmt,
	input  wire logic [2:0] funct3,
	input  wire logic [6:0] funct7,
	input  wire word_t      pc,
	input  wire word_t      src1,
	input  wire word_t      src2,
	input  wire word_t      imm,
	input  wire word_t      csr_val,
	output word_t           val,
	output word_t           jump,
	output logic            jump_en,
	output logic [3:0]      wmask,
	output word_t           csr_wdata,
	output word_t           st_addr
);

	word_t      lop;
	word_t      rop;
	word_t      alu_val;
	word_t      addr_base;
	word_t      addr_sum;
	logic [4:0] shamt;
	logic [3:0] op_sel;
	logic [3:0] base_mask;
	alu_op_e    add_sub;
	alu_op_e    shr_op;
	alu_op_e    alu_op;
	logic       is_arith;
	logic       eq;
	logic       lt;
	logic       ltu;
	logic       take;

	mux_key #(3, 7, 32) i_lop (
		.key(opcode), .default_out(pc), .out(lop),
		.lut({
			OPC_LUI,    32'd0,
			OPC_OP_IMM, src1,
			OPC_OP,     src1
		})
	);

	mux_key #(3, 7, 32) i_rop (
		.key(opcode), .default_out(imm), .out(rop),
		.lut({
			OPC_JAL,  32'd4, // link value pc+4
			OPC_JALR, 32'd4,
			OPC_OP,   src2
		})
	);

	assign is_arith = (fmt == FMT_R) || (fmt == FMT_I && opcode != OPC_JALR);
	assign add_sub  = (fmt == FMT_R && funct7[5]) ? OP_SUB : OP_ADD; // no subi
	assign shr_op   = funct7[5] ? OP_SRA : OP_SRL;

	mux_key #(8, 3, 4) i_op (
		.key(funct3), .default_out(OP_ADD), .out(op_sel),
		.lut({
			F3_ADD,  add_sub,
			F3_SLL,  OP_SLL,
			F3_SLT,  OP_LESS,
			F3_SLTU, OP_ULESS,
			F3_XOR,  OP_XOR,
			F3_SR,   shr_op,
			F3_OR,   OP_OR,
			F3_AND,  OP_AND
		})
	);

	assign alu_op = is_arith ? alu_op_e'(op_sel) : OP_ADD;
	assign shamt  = rop[4:0];

	mux_key #(10, 4, 32) i_res (
		.key(alu_op), .default_out(32'd0), .out(alu_val),
		.lut({
			OP_ADD,   lop + rop,
			OP_SUB,   lop - rop,
			OP_AND,   lop & rop,
			OP_XOR,   lop ^ rop,
			OP_OR,    lop | rop,
			OP_SRL,   lop >> shamt,
			OP_SRA,   word_t'($signed(lop) >>> shamt),
			OP_SLL,   lop << shamt,
			OP_LESS,  {31'd0, $signed(lop) < $signed(rop)},
			OP_ULESS, {31'd0, lop < rop}
		})
	);

	assign val = (opcode == OPC_SYSTEM) ? csr_val : alu_val; // csr reads return old value

	// shared adder for jalr target and store address
	assign addr_base = (opcode == OPC_JALR || opcode == OPC_STORE) ? src1 : pc;
	assign addr_sum  = addr_base + imm;
	assign jump      = {addr_sum[31:1], 1'b0};
	assign st_addr   = addr_sum;

	assign eq  = (src1 == src2);
	assign lt  = $signed(src1) < $signed(src2);
	assign ltu = src1 < src2;

	mux_key #(6, 3, 1) i_cond (
		.key(funct3), .default_out(1'b0), .out(take),
		.lut({
			F3_BEQ,  eq,
			F3_BNE,  ~eq,
			F3_BLT,  lt,
			F3_BGE,  ~lt,
			F3_BLTU, ltu,
			F3_BGEU, ~ltu
		})
	);

	assign jump_en = (opcode == OPC_JAL) || (opcode == OPC_JALR) ||
		(opcode == OPC_BRANCH && take);

	mux_key #(3, 3, 4) i_mask (
		.key(funct3), .default_out(4'h0), .out(base_mask),
		.lut({
			F3_SB, 4'h1,
			F3_SH, 4'h3,
			F3_SW, 4'hf
		})
	);

	assign wmask = base_mask << addr_sum[1:0]; // lanes past byte 3 fall off

	mux_key #(2, 3, 32) i_csr (
		.key(funct3), .default_out(32'd0), .out(csr_wdata),
		.lut({
			F3_CSRRW, src1,
			F3_CSRRS, src1 | csr_val
		})
	);

endmodule

`default_nettype wire

// ==== rv_wbu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_wbu import rv_isa_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst,
	input  wire logic      in_valid,
	input  wire word_t     pc,
	input  wire reg_idx_t  rd,
	input  wire logic      rd_wen,
	input  wire logic      st_en,
	input  wire logic      csr_en,
	input  wire csr_addr_t csr_addr,
	input  wire word_t     val,
	input  wire word_t     jump,
	input  wire logic      jump_en,
	input  wire logic [3:0] wmask,
	input  wire word_t     csr_wdata,
	input  wire word_t     src2,
	input  wire word_t     st_addr,
	output word_t          csr_val,
	output logic           reg_wen,
	output reg_idx_t       reg_waddr,
	output word_t          reg_wdata,
	output logic           out_valid,
	output reg_idx_t       out_rd,
	output logic           out_rd_wen,
	output word_t          out_val,
	output word_t          out_next_pc,
	output logic           st_wen,
	output word_t          st_addr_q,
	output word_t          st_wdata,
	output logic [3:0]     st_wmask,
	output logic           out_csr_wen,
	output csr_addr_t      out_csr_addr,
	output word_t          out_csr_wdata
);

	word_t mscratch;
	word_t mepc;
	logic  csr_hit; // address is one we implement

	assign csr_hit = (csr_addr == CSR_MSCRATCH) || (csr_addr == CSR_MEPC);
	assign csr_val = (csr_addr == CSR_MSCRATCH) ? mscratch :
		(csr_addr == CSR_MEPC) ? mepc : '0;

	// regfile write lands on the same edge
	assign reg_wen   = in_valid && rd_wen;
	assign reg_waddr = rd;
	assign reg_wdata = val;

	always_ff @(posedge clk) begin
		if (rst) begin
			mscratch    <= '0;
			mepc        <= '0;
			out_valid   <= 1'b0;
			out_rd_wen  <= 1'b0;
			st_wen      <= 1'b0;
			out_csr_wen <= 1'b0;
		end else begin
			out_valid   <= in_valid;
			out_rd_wen  <= in_valid && rd_wen;
			st_wen      <= in_valid && st_en;
			out_csr_wen <= in_valid && csr_en && csr_hit;
			if (in_valid && csr_en && csr_addr == CSR_MSCRATCH) begin
				mscratch <= csr_wdata;
			end
			if (in_valid && csr_en && csr_addr == CSR_MEPC) begin
				mepc <= csr_wdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			out_rd        <= rd;
			out_val       <= val;
			out_next_pc   <= jump_en ? jump : pc + 32'd4;
			st_addr_q     <= st_addr;
			st_wdata      <= src2 << {st_addr[1:0], 3'b000}; // into the masked lanes
			st_wmask      <= wmask;
			out_csr_addr  <= csr_addr;
			out_csr_wdata <= csr_wdata;
		end
	end

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_isa_pkg::*, rv_exec_pkg::*; #(
	parameter int NR_REGS = 32
) (
	input  wire logic  clk,
	input  wire logic  rst,
	input  wire logic  in_valid,
	input  wire inst_t inst,
	input  wire word_t pc,
	output logic       out_valid,
	output reg_idx_t   out_rd,
	output logic       out_rd_wen,
	output word_t      out_val,
	output word_t      out_next_pc,
	output logic       st_wen,
	output word_t      st_addr,
	output word_t      st_wdata,
	output logic [3:0] st_wmask,
	output logic       out_csr_wen,
	output csr_addr_t  out_csr_addr,
	output word_t      out_csr_wdata
);

	logic [6:0] opcode;
	fmt_e       fmt;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_idx_t   rs1, rs2, rd, reg_waddr;
	word_t      imm, src1, src2, csr_val, val, jump, csr_wdata, ex_st_addr, reg_wdata;
	logic       rd_wen, st_en, csr_en, jump_en, reg_wen;
	csr_addr_t  csr_addr;
	logic [3:0] wmask;

	rv_idu i_idu (
		.inst, .opcode, .fmt, .funct3, .funct7, .rs1, .rs2, .rd, .imm,
		.rd_wen, .st_en, .csr_en, .csr_addr
	);

	rv_regfile #(.NR_REGS(NR_REGS)) i_regfile (
		.clk, .rst, .rs1, .rs2, .rdata1(src1), .rdata2(src2),
		.wen(reg_wen), .waddr(reg_waddr), .wdata(reg_wdata)
	);

	rv_exu i_exu (
		.opcode, .fmt, .funct3, .funct7, .pc, .src1, .src2, .imm, .csr_val,
		.val, .jump, .jump_en, .wmask, .csr_wdata, .st_addr(ex_st_addr)
	);

	rv_wbu i_wbu (
		.clk, .rst, .in_valid, .pc, .rd, .rd_wen, .st_en, .csr_en, .csr_addr,
		.val, .jump, .jump_en, .wmask, .csr_wdata, .src2, .st_addr(ex_st_addr),
		.csr_val, .reg_wen, .reg_waddr, .reg_wdata,
		.out_valid, .out_rd, .out_rd_wen, .out_val, .out_next_pc,
		.st_wen, .st_addr_q(st_addr), .st_wdata, .st_wmask,
		.out_csr_wen, .out_csr_addr, .out_csr_wdata
	);

endmodule

`default_nettype wire

// ==== rv_core_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_asserts (
	input wire logic clk,
	input wire logic rst,
	input wire logic in_valid,
	input wire logic out_valid,
	input wire logic out_rd_wen,
	input wire logic st_wen,
	input wire logic out_csr_wen
);

	// result strobe trails the input strobe by exactly one edge
	a_valid_delay: assert property (@(posedge clk) !rst |=> out_valid == $past(in_valid))
		else $error("out_valid is not in_valid delayed by one cycle");

	a_reset_quiet: assert property (@(posedge clk) rst |=> !out_valid && !st_wen && !out_csr_wen)
		else $error("control outputs not low in the cycle after reset");

	a_store_no_rd: assert property (@(posedge clk) disable iff (rst) !(st_wen && out_rd_wen))
		else $error("store and register write reported together");

endmodule

bind rv_wbu rv_core_asserts i_asserts (
	.clk(clk),
	.rst(rst),
	.in_valid(in_valid),
	.out_valid(out_valid),
	.out_rd_wen(out_rd_wen),
	.st_wen(st_wen),
	.out_csr_wen(out_csr_wen)
);

`default_nettype wire

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_isa_pkg::*; ();

	localparam int NR_REGS = 32;

	typedef struct packed {
		logic        rd_wen;
		reg_idx_t    rd;
		word_t       val;
		word_t       next_pc;
		logic        st_wen;
		word_t       st_addr;
		word_t       st_wdata;
		logic [3:0]  st_wmask;
		logic        csr_wen;
		csr_addr_t   csr_addr;
		word_t       csr_wdata;
		logic [31:0] cyc; // cycle count at issue
	} result_t;

	logic clk = 1'b0;
	logic rst;
	logic in_valid;
	inst_t inst;
	word_t pc;
	logic out_valid;
	reg_idx_t out_rd;
	logic out_rd_wen;
	word_t out_val;
	word_t out_next_pc;
	logic st_wen;
	word_t st_addr;
	word_t st_wdata;
	logic [3:0] st_wmask;
	logic out_csr_wen;
	csr_addr_t out_csr_addr;
	word_t out_csr_wdata;

	word_t shadow_regs [NR_REGS];
	word_t shadow_mscratch;
	word_t shadow_mepc;
	result_t exp_q [$];
	logic [31:0] cyc = '0;
	integer seed;
	int checks = 0;
	int errors = 0;

	rv_core #(.NR_REGS(NR_REGS)) i_dut (.*);

	always #50 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 32'd1;

	function automatic word_t rand_word();
		return $random(seed);
	endfunction

	function automatic reg_idx_t rand_reg();
		return reg_idx_t'(rand_word() % NR_REGS);
	endfunction

	function automatic word_t rand_pc();
		return rand_word() & 32'hffff_fffc;
	endfunction

	function automatic inst_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
		logic [2:0] f3, reg_idx_t rd, logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic inst_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
		reg_idx_t rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic inst_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
		logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic inst_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic inst_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic inst_t enc_j(logic [20:0] imm, reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	function automatic word_t read_shadow(reg_idx_t idx);
		if (idx == '0 || idx >= NR_REGS) return '0;
		return shadow_regs[idx];
	endfunction

	function automatic word_t read_csr(csr_addr_t ad);
		if (ad == CSR_MSCRATCH) return shadow_mscratch;
		if (ad == CSR_MEPC) return shadow_mepc;
		return '0; // unimplemented csr
	endfunction

	function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t x, word_t y);
		logic [4:0] sh;
		sh = y[4:0]; // only the low 5 bits shift
		case (f3)
			F3_ADD:  return alt ? x - y : x + y;
			F3_SLL:  return x << sh;
			F3_SLT:  return {31'd0, $signed(x) < $signed(y)};
			F3_SLTU: return {31'd0, x < y};
			F3_XOR:  return x ^ y;
			F3_SR: begin
				if (alt) return $signed(x) >>> sh;
				return x >> sh;
			end
			F3_OR:   return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic logic branch_taken(logic [2:0] f3, word_t x, word_t y);
		case (f3)
			F3_BEQ:  return x == y;
			F3_BNE:  return x != y;
			F3_BLT:  return $signed(x) < $signed(y);
			F3_BGE:  return $signed(x) >= $signed(y);
			F3_BLTU: return x < y;
			F3_BGEU: return x >= y;
			default: return 1'b0;
		endcase
	endfunction

	// expected record from the isa rules and the shadow state
	function automatic result_t ref_result(inst_t ins, word_t ipc);
		result_t r;
		word_t a, b, addr, old;
		word_t imm_i, imm_s, imm_b, imm_u, imm_j;
		logic [2:0] f3;
		logic [3:0] m;
		a = read_shadow(ins[19:15]);
		b = read_shadow(ins[24:20]);
		f3 = ins[14:12];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_u = {ins[31:12], 12'd0};
		imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		r = '0;
		r.rd = ins[11:7];
		r.next_pc = ipc + 32'd4;
		r.csr_addr = ins[31:20];
		case (ins[6:0])
			OPC_LUI: begin
				r.rd_wen = 1'b1;
				r.val = imm_u;
			end
			OPC_AUIPC: begin
				r.rd_wen = 1'b1;
				r.val = ipc + imm_u;
			end
			OPC_JAL: begin
				r.rd_wen = 1'b1;
				r.val = ipc + 32'd4;
				r.next_pc = (ipc + imm_j) & 32'hffff_fffe;
			end
			OPC_JALR: begin
				r.rd_wen = 1'b1;
				r.val = ipc + 32'd4;
				r.next_pc = (a + imm_i) & 32'hffff_fffe;
			end
			OPC_BRANCH: begin
				if (branch_taken(f3, a, b)) r.next_pc = (ipc + imm_b) & 32'hffff_fffe;
			end
			OPC_STORE: begin
				addr = a + imm_s;
				m = (f3 == F3_SB) ? 4'h1 : (f3 == F3_SH) ? 4'h3 : (f3 == F3_SW) ? 4'hf : 4'h0;
				r.st_wen = 1'b1;
				r.st_addr = addr;
				r.st_wmask = m << addr[1:0]; // upper lanes drop off
				r.st_wdata = b << {addr[1:0], 3'b000};
			end
			OPC_OP_IMM: begin
				r.rd_wen = 1'b1;
				r.val = alu_model(f3, ins[30] && f3 == F3_SR, a, imm_i); // no subi
			end
			OPC_OP: begin
				r.rd_wen = 1'b1;
				r.val = alu_model(f3, ins[30], a, b);
			end
			OPC_SYSTEM: begin
				if (f3 == F3_CSRRW || f3 == F3_CSRRS) begin
					old = read_csr(r.csr_addr);
					r.rd_wen = 1'b1;
					r.val = old;
					r.csr_wdata = (f3 == F3_CSRRW) ? a : (a | old);
					r.csr_wen = (r.csr_addr == CSR_MSCRATCH) || (r.csr_addr == CSR_MEPC);
				end
			end
			default: ;
		endcase
		return r;
	endfunction

	task automatic check(string name, word_t got, word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic commit(result_t r);
		if (r.rd_wen && r.rd != '0 && r.rd < NR_REGS) shadow_regs[r.rd] = r.val;
		if (r.csr_wen && r.csr_addr == CSR_MSCRATCH) shadow_mscratch = r.csr_wdata;
		if (r.csr_wen && r.csr_addr == CSR_MEPC) shadow_mepc = r.csr_wdata;
	endtask

	task automatic issue(inst_t ins, word_t ipc);
		result_t r;
		@(negedge clk);
		r = ref_result(ins, ipc);
		r.cyc = cyc;
		in_valid = 1'b1;
		inst = ins;
		pc = ipc;
		exp_q.push_back(r);
		commit(r);
	endtask

	task automatic gap();
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic load_reg(reg_idx_t rd, word_t value);
		issue(enc_u(value[31:12] + value[11], rd, OPC_LUI), rand_pc()); // addi sign-extends
		issue(enc_i(value[11:0], rd, F3_ADD, rd, OPC_OP_IMM), rand_pc());
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		gap();
		while (exp_q.size() != 0 && waited < 10) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("ERROR: timed out waiting for %0d outstanding results", exp_q.size());
			exp_q.delete();
		end
	endtask

	task automatic apply_reset();
		rst = 1'b1; // reset takes priority over an instruction still on the inputs
		exp_q.delete();
		@(negedge clk);
		in_valid = 1'b0;
		check("out_valid", out_valid, 0);
		check("out_rd_wen", out_rd_wen, 0);
		check("st_wen", st_wen, 0);
		check("out_csr_wen", out_csr_wen, 0);
		repeat (4) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < NR_REGS; i++) shadow_regs[i] = '0;
		shadow_mscratch = '0;
		shadow_mepc = '0;
	endtask

	// compare each result against the oldest outstanding instruction
	always @(negedge clk) begin
		result_t e;
		if (!rst && out_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("ERROR: out_valid seen with no instruction outstanding");
			end else begin
				e = exp_q.pop_front();
				check("result cycle", cyc, e.cyc + 32'd1);
				check("out_rd_wen", out_rd_wen, e.rd_wen);
				if (e.rd_wen) check("out_rd", out_rd, e.rd);
				if (e.rd_wen) check("out_val", out_val, e.val);
				check("out_next_pc", out_next_pc, e.next_pc);
				check("st_wen", st_wen, e.st_wen);
				if (e.st_wen) begin
					check("st_addr", st_addr, e.st_addr);
					check("st_wdata", st_wdata, e.st_wdata);
					check("st_wmask", st_wmask, e.st_wmask);
				end
				check("out_csr_wen", out_csr_wen, e.csr_wen);
				if (e.csr_wen) begin
					check("out_csr_addr", out_csr_addr, e.csr_addr);
					check("out_csr_wdata", out_csr_wdata, e.csr_wdata);
				end
			end
		end else if (!rst && exp_q.size() != 0 && cyc > exp_q[0].cyc + 32'd1) begin
			errors++;
			$display("ERROR: no out_valid one cycle after in_valid");
			void'(exp_q.pop_front());
		end
	end

	initial begin
		int i;
		int k;
		word_t w;
		logic [2:0] f3;
		logic alt;
		reg_idx_t ra;
		reg_idx_t rb;
		csr_addr_t ad;
		seed = 33;
		rst = 1'b1;
		in_valid = 1'b0;
		inst = '0;
		pc = '0;
		apply_reset();

		for (i = 1; i < NR_REGS; i++) load_reg(reg_idx_t'(i), rand_word());
		for (i = 0; i < 40; i++) begin
			w = rand_word();
			f3 = w[4:2];
			alt = w[5] && (f3 == F3_ADD || f3 == F3_SR);
			if (w[0]) begin
				issue(enc_r({1'b0, alt, 5'd0}, rand_reg(), rand_reg(), f3, rand_reg(), OPC_OP),
					rand_pc());
			end else if (f3 == F3_SLL || f3 == F3_SR) begin
				issue(enc_i({1'b0, alt, 5'd0, w[10:6]}, rand_reg(), f3, rand_reg(), OPC_OP_IMM),
					rand_pc());
			end else begin
				issue(enc_i(w[31:20], rand_reg(), f3, rand_reg(), OPC_OP_IMM), rand_pc());
			end
			if (w[1]) gap(); // idle cycle between some instructions
		end
		wait_drain();

		for (i = 0; i < 6; i++) begin
			w = rand_word();
			issue(enc_u(w[31:12], rand_reg(), OPC_LUI), rand_pc());
			issue(enc_u(w[19:0], rand_reg(), OPC_AUIPC), rand_pc());
			issue(enc_j({w[20:1], 1'b0}, rand_reg()), rand_pc());
			issue(enc_i(w[11:0], rand_reg(), F3_ADD, rand_reg(), OPC_JALR), rand_pc()); // odd targets too
		end
		wait_drain();

		// equal, negative and unsigned-large operand pairs
		load_reg(5'd1, 32'd5);
		load_reg(5'd2, 32'd5);
		load_reg(5'd3, 32'hffff_fffd);
		load_reg(5'd4, 32'hf000_0000);
		for (k = 0; k < 8; k++) begin
			if (k == 2 || k == 3) continue;
			for (i = 0; i < 5; i++) begin
				w = rand_word();
				ra = (i == 1) ? 5'd3 : (i == 3) ? 5'd4 : 5'd1;
				rb = (i == 0) ? 5'd2 : (i == 2) ? 5'd3 : (i == 4) ? 5'd4 : 5'd1;
				issue(enc_b({w[12:1], 1'b0}, rb, ra, 3'(k)), rand_pc());
			end
		end
		wait_drain();

		for (i = 0; i < 12; i++) begin
			w = rand_word();
			issue(enc_s(w[11:0], rand_reg(), rand_reg(), 3'(i % 3)), rand_pc());
		end
		wait_drain();

		for (i = 0; i < 3; i++) begin
			ad = (i == 0) ? CSR_MSCRATCH : (i == 1) ? CSR_MEPC : 12'h300;
			issue(enc_i(ad, rand_reg(), F3_CSRRW, rand_reg(), OPC_SYSTEM), rand_pc());
			issue(enc_i(ad, rand_reg(), F3_CSRRS, rand_reg(), OPC_SYSTEM), rand_pc());
			issue(enc_i(ad, 5'd0, F3_CSRRS, rand_reg(), OPC_SYSTEM), rand_pc()); // plain read
		end
		wait_drain();

		// each instruction reads the previous result
		load_reg(5'd1, rand_word());
		load_reg(5'd2, rand_word());
		issue(enc_r(7'h00, 5'd2, 5'd1, F3_ADD, 5'd6, OPC_OP), rand_pc());
		issue(enc_r(7'h20, 5'd1, 5'd6, F3_ADD, 5'd7, OPC_OP), rand_pc());
		issue(enc_r(7'h00, 5'd6, 5'd7, F3_XOR, 5'd8, OPC_OP), rand_pc());
		issue(enc_i(CSR_MSCRATCH, 5'd8, F3_CSRRW, 5'd9, OPC_SYSTEM), rand_pc());
		issue(enc_i(CSR_MSCRATCH, 5'd0, F3_CSRRS, 5'd10, OPC_SYSTEM), rand_pc());
		wait_drain();
		repeat (3) gap(); // idle cycles with no result expected
		issue(enc_i(CSR_MSCRATCH, 5'd8, F3_CSRRW, 5'd12, OPC_SYSTEM), rand_pc());
		apply_reset(); // asserted on the edge that samples the csrrw
		issue(enc_r(7'h00, 5'd7, 5'd6, F3_ADD, 5'd11, OPC_OP), rand_pc());
		issue(enc_i(CSR_MSCRATCH, 5'd0, F3_CSRRS, 5'd12, OPC_SYSTEM), rand_pc());
		wait_drain();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== rv_core.f ====
rv_isa_pkg.sv
rv_exec_pkg.sv
mux_key.sv
rv_regfile.sv
rv_idu.sv
rv_exu.sv
rv_wbu.sv
rv_core.sv
rv_core_asserts.sv
tb_rv_core.sv
